// ==== sources.f ====
+incdir+hdl
hdl/apple1_bus_pkg.sv
hdl/apple1_serial_pkg.sv
hdl/periph_bus_if.sv
hdl/cpu_clock_enable.sv
hdl/pwr_reset.sv
hdl/bus_decoder.sv
hdl/main_ram.sv
hdl/serial_terminal.sv
hdl/apple1_core.sv
verif/tb_apple1_core.sv

// ==== verif/tb_apple1_core.sv ====
// Directed testbench for the Apple-1 memory and peripheral core
// CPU bus model, 8N1 line models, value checks and a cycle timeout
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module tb_apple1_core;
    import apple1_bus_pkg::*;

    localparam int period      = `CPU_CLK_DIV;          // clk25 cycles per CPU cycle
    localparam int access_len  = 2 * period;            // Sync plus one held period
    localparam int frame_len   = 10 * `UART_DIV;        // Start, 8 data, stop
    localparam int ram_n       = 8;                     // Random RAM writes
    localparam int reset_len   = 10 + (`RESET_HOLD + 1) * period;
    localparam int ram_len     = (2 * ram_n + 2) * access_len;
    localparam int mode_len    = 4 * access_len;
    localparam int tx_len      = frame_len + 3 * access_len;
    localparam int rx_len      = frame_len + 3 * access_len;
    localparam int cycle_limit = 2 * (reset_len + ram_len + mode_len + tx_len + rx_len);

    logic   clk25;
    logic   rst;
    addr_t  cpu_addr;
    data_t  cpu_wdata;
    logic   cpu_we;
    data_t  cpu_rdata;
    logic   cpu_clken;
    logic   cpu_rst;
    logic   serial_rx;
    logic   serial_tx;
    logic   serial_cts;
    mode_t  display_mode;
    integer seed   = 32'hcad7;
    int     cycles = 0;

    apple1_core dut
    (
        .clk25        (clk25),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_we       (cpu_we),
        .cpu_rdata    (cpu_rdata),
        .cpu_clken    (cpu_clken),
        .cpu_rst      (cpu_rst),
        .serial_rx    (serial_rx),
        .serial_tx    (serial_tx),
        .serial_cts   (serial_cts),
        .display_mode (display_mode)
    );

    always #50 clk25 = ~clk25;    // 100 ns period

    // Watchdog
    always @(posedge clk25)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout: tests still running after %0d clk25 cycles", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // Checking and bus helpers

    task automatic fail_now(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else fail_now($sformatf("%s is %0h, expected %0h", what, got, exp));
    endtask

    // Returns just after the next enabled clk25 edge
    task automatic next_enable();
        @(negedge clk25);
        while (!cpu_clken)
            @(negedge clk25);
        @(posedge clk25);
        #1;
    endtask

    // One CPU cycle, address held for a full enable period
    task automatic cpu_access(input addr_t addr, input data_t wdata, input logic we,
                              output data_t rdata);
        next_enable();
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_we    = we;
        @(negedge clk25);
        while (!cpu_clken)
            @(negedge clk25);
        rdata = cpu_rdata;           // Sampled just before the enabled edge
        @(posedge clk25);
        #1;
        cpu_addr = 16'h8000;         // Park unmapped so no read side effect
        cpu_we   = 1'b0;
    endtask

    task automatic cpu_write(input addr_t addr, input data_t wdata);
        data_t ignored;
        cpu_access(addr, wdata, 1'b1, ignored);
    endtask

    task automatic cpu_read(input addr_t addr, output data_t rdata);
        cpu_access(addr, 8'h00, 1'b0, rdata);
    endtask

    //////////////////////////////////////////////////
    // Serial line models

    task automatic send_rx_frame(input data_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};                 // Stop, data, start
        @(posedge clk25);
        #1;
        for (int i = 0; i < 10; i++)
        begin
            serial_rx = frame[i];                    // LSB first after start
            repeat (`UART_DIV) @(posedge clk25);
            #1;
        end
    endtask

    // Call right after the enabled edge of the data write
    task automatic capture_tx_frame(input data_t expected);
        logic [9:0] frame;
        repeat (`UART_DIV / 2) @(negedge clk25);     // Middle of the start bit
        for (int i = 0; i < 10; i++)
        begin
            frame[i] = serial_tx;
            if (i < 9)
                repeat (`UART_DIV) @(negedge clk25);
        end
        check_value("tx start bit", frame[0], 1'b0);
        check_value("tx data byte", frame[8:1], expected);
        check_value("tx stop bit", frame[9], 1'b1);
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset();
        int pulses;
        pulses = 0;
        repeat (5) @(posedge clk25);
        #1;
        check_value("cpu_rst in reset", cpu_rst, 1'b1);
        check_value("serial_tx in reset", serial_tx, 1'b1);
        check_value("serial_cts in reset", serial_cts, 1'b1);
        check_value("display_mode in reset", display_mode, 2'd0);
        check_value("cpu_clken in reset", cpu_clken, 1'b0);
        repeat (5) @(posedge clk25);
        #1;
        rst = 1'b0;                                  // Ten cycles in total
        while (cpu_rst)
        begin
            @(negedge clk25);
            if (cpu_clken)
                pulses++;
        end
        check_value("enable pulses before cpu_rst falls", pulses, `RESET_HOLD);
    endtask

    task automatic test_ram();
        data_t model [addr_t];
        addr_t keys [$];
        addr_t addr;
        data_t value;
        data_t got;
        for (int i = 0; i < ram_n; i++)
        begin
            addr  = addr_t'($random(seed)) & `RAM_TOP;
            value = data_t'($random(seed));
            cpu_write(addr, value);
            model[addr] = value;                     // Repeated address keeps the last byte
            keys.push_back(addr);
        end
        addr = keys[0];
        cpu_access(addr, ~model[addr], 1'b0, got);   // Data on the bus, no strobe
        foreach (keys[i])
        begin
            cpu_read(keys[i], got);
            check_value($sformatf("RAM byte at %h", keys[i]), got, model[keys[i]]);
        end
    endtask

    task automatic test_mode();
        data_t value;
        data_t got;
        cpu_read(16'h8000, got);
        check_value("unmapped read at 8000", got, 8'hFF);
        cpu_read(16'hF000, got);
        check_value("unmapped read at F000", got, 8'hFF);
        value = data_t'($random(seed)) | 8'h01;      // Never the reset value
        cpu_write(`MODE_BASE, value);
        check_value("display_mode", display_mode, value[1:0]);
        cpu_read(`MODE_BASE, got);
        check_value("mode register read", got, {6'b0, value[1:0]});
    endtask

    task automatic test_transmit();
        data_t value;
        data_t got;
        value = data_t'($random(seed));
        cpu_write(`TERM_BASE + 16'd2, value);
        fork
            capture_tx_frame(value);
            begin
                cpu_read(`TERM_BASE + 16'd3, got);   // Lands mid frame
                check_value("tx busy during frame", got[7], 1'b1);
            end
        join
        cpu_read(`TERM_BASE + 16'd3, got);
        check_value("tx busy after frame", got[7], 1'b0);
    endtask

    task automatic test_receive();
        data_t value;
        data_t got;
        value = data_t'($random(seed));
        send_rx_frame(value);
        check_value("serial_cts with byte held", serial_cts, 1'b0);
        cpu_read(`TERM_BASE + 16'd1, got);
        check_value("rx ready after frame", got[7], 1'b1);
        cpu_read(`TERM_BASE, got);                   // Clears ready
        check_value("rx data byte", got, value);
        cpu_read(`TERM_BASE + 16'd1, got);
        check_value("rx ready after data read", got[7], 1'b0);
        check_value("serial_cts after data read", serial_cts, 1'b1);
    endtask

    initial
    begin
        clk25     = 1'b0;
        rst       = 1'b1;
        cpu_addr  = 16'h8000;
        cpu_wdata = 8'h00;
        cpu_we    = 1'b0;
        serial_rx = 1'b1;                            // Idle line
        test_reset();
        test_ram();
        test_mode();
        test_transmit();
        test_receive();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/apple1_core.sv ====
// Top level of the memory and peripheral core
// Clock enable, reset stretcher, decoder, RAM and serial terminal
`timescale 1ns/10ps
`default_nettype none

module apple1_core
(
    input  wire                        clk25,
    input  wire                        rst,
    input  wire apple1_bus_pkg::addr_t cpu_addr,
    input  wire apple1_bus_pkg::data_t cpu_wdata,
    input  wire                        cpu_we,
    output wire apple1_bus_pkg::data_t cpu_rdata,
    output wire                        cpu_clken,
    output wire                        cpu_rst,
    input  wire                        serial_rx,
    output wire                        serial_tx,
    output wire                        serial_cts,
    output wire apple1_bus_pkg::mode_t display_mode
);
    periph_bus_if ram_bus();
    periph_bus_if term_bus();

    cpu_clock_enable u_clken
    (
        .clk25     (clk25),
        .rst       (rst),
        .cpu_clken (cpu_clken)
    );

    pwr_reset u_reset
    (
        .clk25     (clk25),
        .rst       (rst),
        .cpu_clken (cpu_clken),
        .sys_rst   (cpu_rst)           // CPU side reset, also for the peripherals
    );

    bus_decoder u_decoder
    (
        .clk25        (clk25),
        .rst          (cpu_rst),
        .cpu_clken    (cpu_clken),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_we       (cpu_we),
        .cpu_rdata    (cpu_rdata),
        .display_mode (display_mode),
        .ram_bus      (ram_bus.ctrl),
        .term_bus     (term_bus.ctrl)
    );

    main_ram u_ram
    (
        .clk25 (clk25),
        .bus   (ram_bus.dev)
    );

    serial_terminal u_term
    (
        .clk25      (clk25),
        .rst        (cpu_rst),
        .bus        (term_bus.dev),
        .serial_rx  (serial_rx),
        .serial_tx  (serial_tx),
        .serial_cts (serial_cts)
    );

endmodule

`default_nettype wire

// ==== hdl/serial_terminal.sv ====
// Serial terminal port, 8N1 transmit and receive
// Data and status registers, send-ready flag on serial_cts
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module serial_terminal
(
    input  wire       clk25,
    input  wire       rst,
    periph_bus_if.dev bus,
    input  wire       serial_rx,
    output logic      serial_tx,
    output logic      serial_cts
);
    import apple1_bus_pkg::*;
    import apple1_serial_pkg::*;

    // Register map
    localparam reg_sel_t rx_data_reg = 2'd0;    // Read clears ready
    localparam reg_sel_t rx_stat_reg = 2'd1;
    localparam reg_sel_t tx_data_reg = 2'd2;
    localparam reg_sel_t tx_stat_reg = 2'd3;

    localparam baud_cnt_t baud_last = baud_cnt_t'(`UART_DIV - 1);
    localparam baud_cnt_t baud_half = baud_cnt_t'(`UART_DIV / 2 - 1);
    localparam bit_cnt_t  bit_last  = 4'd7;

    reg_sel_t      reg_sel;
    logic          tx_load;
    logic          tx_busy;
    logic          rd_clear;
    serial_state_t tx_state;
    baud_cnt_t     tx_baud;
    bit_cnt_t      tx_bit;
    data_t         tx_shift;
    serial_state_t rx_state;
    baud_cnt_t     rx_baud;
    bit_cnt_t      rx_bit;
    data_t         rx_shift;
    data_t         rx_data;
    logic          rx_ready;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_bit_tick;
    logic          rx_stop_ok;

    assign reg_sel  = bus.addr[1:0];
    assign tx_busy  = (tx_state != idle);
    assign tx_load  = bus.we && (reg_sel == tx_data_reg) && !tx_busy;  // Dropped while busy
    assign rd_clear = bus.sel && !bus.we && (reg_sel == rx_data_reg);
    assign serial_cts = ~rx_ready;         // Hold off the host while a byte waits

    //////////////////////////////////////////////////
    // Transmitter

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            tx_state  <= idle;
            tx_baud   <= '0;
            tx_bit    <= '0;
            serial_tx <= 1'b1;             // Line idles high
        end
        else
        begin
            case (tx_state)
                idle:
                    if (tx_load)
                    begin
                        tx_state  <= start;
                        tx_baud   <= '0;
                        serial_tx <= 1'b0;           // Start bit right away
                    end
                start:
                    if (tx_baud == baud_last)
                    begin
                        tx_state  <= data;
                        tx_baud   <= '0;
                        tx_bit    <= '0;
                        serial_tx <= tx_shift[0];    // LSB first
                    end
                    else
                        tx_baud <= tx_baud + 1'b1;
                data:
                    if (tx_baud == baud_last)
                    begin
                        tx_baud <= '0;
                        tx_bit  <= tx_bit + 1'b1;
                        if (tx_bit == bit_last)
                        begin
                            tx_state  <= stop;
                            serial_tx <= 1'b1;
                        end
                        else
                            serial_tx <= tx_shift[1];  // Next bit before the shift lands
                    end
                    else
                        tx_baud <= tx_baud + 1'b1;
                default:                             // Stop bit, busy until its end
                    if (tx_baud == baud_last)
                        tx_state <= idle;
                    else
                        tx_baud <= tx_baud + 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Receiver

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_state <= idle;
            rx_baud  <= '0;
            rx_bit   <= '0;
            rx_ready <= 1'b0;
        end
        else
        begin
            rx_meta <= serial_rx;          // Two flop synchronizer
            rx_sync <= rx_meta;
            if (rd_clear)
                rx_ready <= 1'b0;
            case (rx_state)
                idle:
                begin
                    rx_baud <= '0;
                    if (!rx_sync)
                        rx_state <= start;           // Falling edge of start bit
                end
                start:
                    if (rx_baud == baud_half)        // Middle of start bit
                    begin
                        rx_baud  <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync ? idle : data;  // Glitch goes back to idle
                    end
                    else
                        rx_baud <= rx_baud + 1'b1;
                data:
                    if (rx_baud == baud_last)
                    begin
                        rx_baud <= '0;
                        rx_bit  <= rx_bit + 1'b1;
                        if (rx_bit == bit_last)
                            rx_state <= stop;
                    end
                    else
                        rx_baud <= rx_baud + 1'b1;
                default:
                    if (rx_baud == baud_last)
                    begin
                        rx_state <= idle;
                        if (rx_sync)
                            rx_ready <= 1'b1;        // Set wins over a same-cycle clear
                    end
                    else
                        rx_baud <= rx_baud + 1'b1;
            endcase
        end
    end

    assign rx_bit_tick = (rx_state == data) && (rx_baud == baud_last);
    assign rx_stop_ok  = (rx_state == stop) && (rx_baud == baud_last) && rx_sync;

    // Shift registers, held byte and read data
    always_ff @(posedge clk25)
    begin
        if (tx_load)
            tx_shift <= bus.wdata;
        else if ((tx_state == data) && (tx_baud == baud_last))
            tx_shift <= {1'b0, tx_shift[7:1]};
        if (rx_bit_tick)
            rx_shift <= {rx_sync, rx_shift[7:1]};    // LSB arrives first
        if (rx_stop_ok)
            rx_data <= rx_shift;                     // Overrun overwrites
        case (reg_sel)
            rx_data_reg: bus.rdata <= rx_data;
            rx_stat_reg: bus.rdata <= {rx_ready, 7'b0};
            tx_stat_reg: bus.rdata <= {tx_busy, 7'b0};
            default:     bus.rdata <= '0;            // Transmit data is write only
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/main_ram.sv ====
// Main memory, 8 KB
// Synchronous write, read registered every cycle
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module main_ram
(
    input  wire       clk25,
    periph_bus_if.dev bus
);
    import apple1_bus_pkg::*;

    localparam int ram_words = `RAM_TOP + 1;    // 8192 bytes

    data_t mem [ram_words];

    always_ff @(posedge clk25)
    begin
        if (bus.we)
            mem[bus.addr] <= bus.wdata;    // Strobe carries select and enable
        bus.rdata <= mem[bus.addr];        // Valid one cycle after the address
    end

endmodule

`default_nettype wire

// ==== hdl/bus_decoder.sv ====
// Address decoder for the CPU bus
// Chip selects, gated write strobes, display mode register, read data mux
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module bus_decoder
(
    input  wire                        clk25,
    input  wire                        rst,
    input  wire                        cpu_clken,
    input  wire apple1_bus_pkg::addr_t cpu_addr,
    input  wire apple1_bus_pkg::data_t cpu_wdata,
    input  wire                        cpu_we,
    output apple1_bus_pkg::data_t      cpu_rdata,
    output apple1_bus_pkg::mode_t      display_mode,
    periph_bus_if.ctrl                 ram_bus,
    periph_bus_if.ctrl                 term_bus
);
    import apple1_bus_pkg::*;

    localparam addr_t ram_top   = `RAM_TOP;
    localparam addr_t term_base = `TERM_BASE;
    localparam addr_t mode_base = `MODE_BASE;

    logic ram_cs;
    logic term_cs;
    logic mode_cs;

    //////////////////////////////////////////////////
    // Chip selects

    assign ram_cs  = (cpu_addr <= ram_top);                  // 0x0000 .. 0x1FFF
    assign term_cs = (cpu_addr[15:2] == term_base[15:2]);    // 0xD010 .. 0xD013
    assign mode_cs = (cpu_addr[15:12] == mode_base[15:12]);  // Whole 0xCxxx page

    // Selects and strobes only count on the enabled edge
    assign ram_bus.sel   = ram_cs & cpu_clken;
    assign ram_bus.addr  = cpu_addr[12:0];
    assign ram_bus.wdata = cpu_wdata;
    assign ram_bus.we    = ram_bus.sel & cpu_we;

    assign term_bus.sel   = term_cs & cpu_clken;   // Also marks the read that clears ready
    assign term_bus.addr  = cpu_addr[12:0];
    assign term_bus.wdata = cpu_wdata;
    assign term_bus.we    = term_bus.sel & cpu_we;

    //////////////////////////////////////////////////
    // Display mode register

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            display_mode <= '0;
        else if (mode_cs && cpu_we && cpu_clken)
            display_mode <= cpu_wdata[1:0];        // Low two bits only
    end

    // Read data, first match wins
    always_comb
    begin
        if (ram_cs)
            cpu_rdata = ram_bus.rdata;
        else if (term_cs)
            cpu_rdata = term_bus.rdata;
        else if (mode_cs)
            cpu_rdata = data_t'(display_mode);     // Zero extended
        else
            cpu_rdata = `UNMAPPED_DATA;            // ROM ranges land here too
    end

endmodule

`default_nettype wire

// ==== hdl/pwr_reset.sv ====
// Reset stretcher for the CPU side
// Holds sys_rst for RESET_HOLD enable pulses after rst drops
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module pwr_reset
(
    input  wire  clk25,
    input  wire  rst,
    input  wire  cpu_clken,
    output logic sys_rst
);
    localparam int               hold_w    = $clog2(`RESET_HOLD + 1);
    localparam logic [hold_w-1:0] hold_last = hold_w'(`RESET_HOLD - 1);

    logic [hold_w-1:0] pulse_cnt;   // Enable pulses seen so far

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            pulse_cnt <= '0;
            sys_rst   <= 1'b1;
        end
        else if (sys_rst && cpu_clken)
        begin
            // Release on the last pulse itself, so reset ends aligned to the enable
            if (pulse_cnt == hold_last)
                sys_rst <= 1'b0;
            else
                pulse_cnt <= pulse_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_clock_enable.sv ====
// CPU clock enable divider
// One clk25 wide pulse every CPU_CLK_DIV cycles
`timescale 1ns/10ps
`default_nettype none
`include "apple1_defines.svh"

module cpu_clock_enable
(
    input  wire  clk25,
    input  wire  rst,
    output logic cpu_clken
);
    localparam int              div_w    = $clog2(`CPU_CLK_DIV);
    localparam logic [div_w-1:0] div_last = div_w'(`CPU_CLK_DIV - 1);
    localparam logic [div_w-1:0] pulse_at = div_w'(`CPU_CLK_DIV - 2);  // Registered one early

    logic [div_w-1:0] div_cnt;

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            cpu_clken <= 1'b0;                               // Quiet while in reset
        end
        else
        begin
            div_cnt   <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;  // Wraps
            cpu_clken <= (div_cnt == pulse_at);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/periph_bus_if.sv ====
// Peripheral bus from the address decoder to one device
// Select, address, write data, write strobe and read data
`timescale 1ns/10ps
`default_nettype none

interface periph_bus_if;
    import apple1_bus_pkg::*;

    logic      sel;      // Device selected, qualified by the CPU enable
    ram_addr_t addr;     // Word address, terminal uses bits 1:0
    data_t     wdata;    // CPU write data
    logic      we;       // Write strobe, already gated
    data_t     rdata;    // Registered read data from the device

    // Decoder side
    modport ctrl
    (
        output sel, addr, wdata, we,
        input  rdata
    );

    // Device side
    modport dev
    (
        input  sel, addr, wdata, we,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hdl/apple1_serial_pkg.sv ====
// Serial frame counter types and the shared 8N1 state enum
`default_nettype none

package apple1_serial_pkg;

    typedef logic [3:0]  bit_cnt_t;     // Data bit index in a frame
    typedef logic [15:0] baud_cnt_t;    // clk25 count within one bit

    // Same encoding for the transmitter and the receiver
    typedef enum logic [1:0] {
        idle,     // Line high, waiting
        start,    // Start bit
        data,     // Eight data bits, LSB first
        stop      // Stop bit
    } serial_state_t;

endpackage

`default_nettype wire

// ==== hdl/apple1_bus_pkg.sv ====
// CPU bus types shared by the decoder, memory, terminal and top level
`default_nettype none

package apple1_bus_pkg;

    // CPU side of the bus
    typedef logic [15:0] addr_t;     // Full 6502 address
    typedef logic [7:0]  data_t;     // One data byte

    // RAM word address, 8 KB deep
    typedef logic [12:0] ram_addr_t;

    // Register index inside a peripheral
    typedef logic [1:0]  reg_sel_t;

    // Display mode latched at 0xC000
    typedef logic [1:0]  mode_t;

endpackage

`default_nettype wire

// ==== hdl/apple1_defines.svh ====
// Clock divide, reset hold and baud divide values
// Address map bases and the unmapped read value
`ifndef APPLE1_DEFINES_SVH
`define APPLE1_DEFINES_SVH

//////////////////////////////////////////////////
// Timing

`define CPU_CLK_DIV   25          // 25 MHz down to a 1 MHz CPU enable
`define RESET_HOLD    4           // Enable pulses before the CPU leaves reset
`define UART_DIV      16          // clk25 cycles per serial bit, fast for simulation

//////////////////////////////////////////////////
// Address map

`define RAM_TOP       16'h1FFF    // RAM from 0x0000 up to here
`define TERM_BASE     16'hD010    // Four terminal registers
`define MODE_BASE     16'hC000    // Display mode register page

// Value seen on reads where nothing answers
`define UNMAPPED_DATA 8'hFF

`endif
